// File: vertex_job_pkg.sv
/*
 * Shared definitions of the vertex job control unit
 *   sizes of fields, lines, addresses and the job queue
 *   vertex array tags in read issue order
 *   read sequencer states
 *   byte swap of one vertex field
 */
`default_nettype none

package vertex_job_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Sizes
	////////////////////////////////////////////////////////////////////////////
	localparam int VERTEX_BITS          = 32;
	localparam int CACHELINE_BITS       = 128;
	localparam int CACHELINE_BYTES      = 16;
	localparam int CACHELINE_VERTEX_NUM = 4;
	localparam int ADDR_BITS            = 32;
	localparam int JOB_QUEUE_DEPTH      = 16;

	// One line register per vertex array
	localparam int VERTEX_ARRAY_NUM   = 6;
	localparam int JOB_QUEUE_PTR_BITS = $clog2(JOB_QUEUE_DEPTH);
	// Queue entry holds the id and the six fields
	localparam int VERTEX_RECORD_BITS = (VERTEX_ARRAY_NUM + 1) * VERTEX_BITS;

	////////////////////////////////////////////////////////////////////////////
	// Encodings
	////////////////////////////////////////////////////////////////////////////
	typedef enum logic [2:0] {
		IN_DEGREE      = 3'd0,
		OUT_DEGREE     = 3'd1,
		EDGES_IDX      = 3'd2,
		INV_IN_DEGREE  = 3'd3,
		INV_OUT_DEGREE = 3'd4,
		INV_EDGES_IDX  = 3'd5
	} vertex_array_e;

	typedef enum logic [2:0] {
		SEQ_RESET,
		SEQ_INIT,
		SEQ_WAIT,
		SEQ_CALC,
		SEQ_SEND
	} seq_state_e;

	// Memory holds fields in the opposite byte order
	function automatic logic [VERTEX_BITS-1:0] swap_endianness_vertex(
		input logic [VERTEX_BITS-1:0] value
	);
		logic [VERTEX_BITS-1:0] swapped;
		for (int i = 0; i < VERTEX_BITS / 8; i++) begin
			swapped[8*i +: 8] = value[VERTEX_BITS-8-8*i +: 8];
		end
		return swapped;
	endfunction

endpackage

`default_nettype wire

// File: vertex_read_sequencer.sv
/*
 * Vertex read sequencer
 *   job setup, chunk split of the vertex count
 *   six read commands per chunk, one per vertex array
 *   outstanding response count and busy flag
 */
`timescale 1ns/10ps
`default_nettype none

module vertex_read_sequencer (
	input  wire                                    clock,
	input  wire                                    rstn,
	input  wire                                    job_start,
	input  wire  [vertex_job_pkg::ADDR_BITS-1:0]   vertex_in_degree_base,
	input  wire  [vertex_job_pkg::ADDR_BITS-1:0]   vertex_out_degree_base,
	input  wire  [vertex_job_pkg::ADDR_BITS-1:0]   vertex_edges_idx_base,
	input  wire  [vertex_job_pkg::ADDR_BITS-1:0]   inverse_in_degree_base,
	input  wire  [vertex_job_pkg::ADDR_BITS-1:0]   inverse_out_degree_base,
	input  wire  [vertex_job_pkg::ADDR_BITS-1:0]   inverse_edges_idx_base,
	input  wire  [vertex_job_pkg::VERTEX_BITS-1:0] num_vertices,
	input  wire                                    resp_valid,
	input  wire                                    drain_busy,
	input  wire                                    chunk_room,
	output logic                                   rd_valid,
	output logic [vertex_job_pkg::ADDR_BITS-1:0]   rd_addr,
	output vertex_job_pkg::vertex_array_e          rd_array,
	output logic [vertex_job_pkg::VERTEX_BITS-1:0] rd_count,
	output logic                                   busy
);
	import vertex_job_pkg::*;

	seq_state_e             state;
	seq_state_e             next_state;
	logic [ADDR_BITS-1:0]   base_q [VERTEX_ARRAY_NUM];
	logic [ADDR_BITS-1:0]   chunk_offset;
	logic [VERTEX_BITS-1:0] vertices_left;
	logic [VERTEX_BITS-1:0] chunk_size;
	logic [3:0]             outstanding;
	vertex_array_e          send_array;
	logic                   chunk_ready;
	logic                   job_done;

	// A new chunk needs the previous one fully returned and drained
	assign chunk_ready = (vertices_left != '0) && (outstanding == '0) && !rd_valid &&
		!drain_busy && chunk_room;
	assign job_done = (vertices_left == '0) && (outstanding == '0) && !rd_valid && !drain_busy;
	assign chunk_size = (vertices_left > VERTEX_BITS'(CACHELINE_VERTEX_NUM)) ?
		VERTEX_BITS'(CACHELINE_VERTEX_NUM) : vertices_left;

	////////////////////////////////////////////////////////////////////////////
	// State machine
	////////////////////////////////////////////////////////////////////////////
	always_comb begin
		next_state = state;
		case (state)
			SEQ_RESET: if (job_start) next_state = SEQ_INIT;
			SEQ_INIT:  next_state = SEQ_WAIT;
			SEQ_WAIT: begin
				if (job_done)
					next_state = SEQ_RESET;
				else if (chunk_ready)
					next_state = SEQ_CALC;
			end
			SEQ_CALC:  next_state = SEQ_SEND;
			SEQ_SEND:  if (send_array == INV_EDGES_IDX) next_state = SEQ_WAIT;
			default:   next_state = SEQ_RESET;
		endcase
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state         <= SEQ_RESET;
			busy          <= 1'b0;
			rd_valid      <= 1'b0;
			vertices_left <= '0;
			chunk_offset  <= '0;
			send_array    <= IN_DEGREE;
		end else begin
			state    <= next_state;
			rd_valid <= (state == SEQ_SEND);
			case (state)
				SEQ_RESET: begin
					if (job_start) begin
						busy          <= 1'b1;
						vertices_left <= num_vertices;
					end
				end
				SEQ_INIT: chunk_offset <= '0;
				SEQ_WAIT: if (job_done) busy <= 1'b0;
				SEQ_CALC: begin
					vertices_left <= vertices_left - chunk_size;
					send_array    <= IN_DEGREE;
				end
				SEQ_SEND: begin
					// Offset moves on once the last array of the chunk is out
					if (send_array == INV_EDGES_IDX)
						chunk_offset <= chunk_offset + ADDR_BITS'(CACHELINE_BYTES);
					else
						send_array <= vertex_array_e'(send_array + 3'd1);
				end
				default: ;
			endcase
		end
	end

	// Job bases and command payload
	always_ff @(posedge clock) begin
		if (state == SEQ_RESET && job_start) begin
			base_q[IN_DEGREE]      <= vertex_in_degree_base;
			base_q[OUT_DEGREE]     <= vertex_out_degree_base;
			base_q[EDGES_IDX]      <= vertex_edges_idx_base;
			base_q[INV_IN_DEGREE]  <= inverse_in_degree_base;
			base_q[INV_OUT_DEGREE] <= inverse_out_degree_base;
			base_q[INV_EDGES_IDX]  <= inverse_edges_idx_base;
		end
		if (state == SEQ_CALC)
			rd_count <= chunk_size;
		if (state == SEQ_SEND) begin
			rd_addr  <= base_q[send_array] + chunk_offset;
			rd_array <= send_array;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Outstanding responses
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			outstanding <= '0;
		else if (rd_valid && !resp_valid)
			outstanding <= outstanding + 4'd1;
		else if (resp_valid && !rd_valid)
			outstanding <= outstanding - 4'd1;
	end

	// Memory side answers only commands it was given
	a_resp_has_command: assert property (
		@(posedge clock) disable iff (!rstn) resp_valid |-> (outstanding != '0)
	);

endmodule

`default_nettype wire

// File: vertex_line_collector.sv
/*
 * Vertex line collector
 *   six line registers filled by array tag
 *   field shift out with byte swap once a chunk is complete
 *   running vertex id
 */
`timescale 1ns/10ps
`default_nettype none

module vertex_line_collector (
	input  wire                                       clock,
	input  wire                                       rstn,
	input  wire                                       job_start,
	input  wire                                       rd_valid,
	input  wire vertex_job_pkg::vertex_array_e        rd_array,
	input  wire  [vertex_job_pkg::VERTEX_BITS-1:0]    rd_count,
	input  wire                                       resp_valid,
	input  wire vertex_job_pkg::vertex_array_e        resp_array,
	input  wire  [vertex_job_pkg::CACHELINE_BITS-1:0] resp_data,
	output logic                                      rec_valid,
	output logic [vertex_job_pkg::VERTEX_BITS-1:0]    rec_id,
	output logic [vertex_job_pkg::VERTEX_BITS-1:0]    rec_in_degree,
	output logic [vertex_job_pkg::VERTEX_BITS-1:0]    rec_out_degree,
	output logic [vertex_job_pkg::VERTEX_BITS-1:0]    rec_edges_idx,
	output logic [vertex_job_pkg::VERTEX_BITS-1:0]    rec_inverse_in_degree,
	output logic [vertex_job_pkg::VERTEX_BITS-1:0]    rec_inverse_out_degree,
	output logic [vertex_job_pkg::VERTEX_BITS-1:0]    rec_inverse_edges_idx,
	output logic                                      drain_busy
);
	import vertex_job_pkg::*;

	logic [CACHELINE_BITS-1:0]   line_q [VERTEX_ARRAY_NUM];
	logic [VERTEX_ARRAY_NUM-1:0] present;
	logic [VERTEX_BITS-1:0]      chunk_size;
	logic [VERTEX_BITS-1:0]      drain_idx;
	logic [VERTEX_BITS-1:0]      id_q;
	logic                        drain_last;

	// Drain runs while all six lines of the chunk are held
	assign rec_valid  = &present;
	assign drain_busy = |present;
	assign drain_last = rec_valid && (drain_idx == chunk_size - VERTEX_BITS'(1));

	////////////////////////////////////////////////////////////////////////////
	// Record assembly from the top field of each line
	////////////////////////////////////////////////////////////////////////////
	assign rec_id = id_q;
	assign rec_in_degree =
		swap_endianness_vertex(line_q[IN_DEGREE][CACHELINE_BITS-1 -: VERTEX_BITS]);
	assign rec_out_degree =
		swap_endianness_vertex(line_q[OUT_DEGREE][CACHELINE_BITS-1 -: VERTEX_BITS]);
	assign rec_edges_idx =
		swap_endianness_vertex(line_q[EDGES_IDX][CACHELINE_BITS-1 -: VERTEX_BITS]);
	assign rec_inverse_in_degree =
		swap_endianness_vertex(line_q[INV_IN_DEGREE][CACHELINE_BITS-1 -: VERTEX_BITS]);
	assign rec_inverse_out_degree =
		swap_endianness_vertex(line_q[INV_OUT_DEGREE][CACHELINE_BITS-1 -: VERTEX_BITS]);
	assign rec_inverse_edges_idx =
		swap_endianness_vertex(line_q[INV_EDGES_IDX][CACHELINE_BITS-1 -: VERTEX_BITS]);

	////////////////////////////////////////////////////////////////////////////
	// Line capture and drain control
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			present   <= '0;
			drain_idx <= '0;
			id_q      <= '0;
		end else begin
			if (resp_valid)
				present[resp_array] <= 1'b1;
			if (drain_last) begin
				present   <= '0;
				drain_idx <= '0;
			end else if (rec_valid) begin
				drain_idx <= drain_idx + VERTEX_BITS'(1);
			end
			// Ids restart with each job
			if (job_start)
				id_q <= '0;
			else if (rec_valid)
				id_q <= id_q + VERTEX_BITS'(1);
		end
	end

	always_ff @(posedge clock) begin
		// Chunk size travels with the first command of the chunk
		if (rd_valid && rd_array == IN_DEGREE)
			chunk_size <= rd_count;
		for (int a = 0; a < VERTEX_ARRAY_NUM; a++) begin
			if (resp_valid && resp_array == vertex_array_e'(a))
				line_q[a] <= resp_data;
			else if (rec_valid)
				line_q[a] <= line_q[a] << VERTEX_BITS;
		end
	end

	// One response per array and chunk
	a_no_double_line: assert property (
		@(posedge clock) disable iff (!rstn) resp_valid |-> !present[resp_array]
	);

endmodule

`default_nettype wire

// File: vertex_job_queue.sv
/*
 * Vertex job queue
 *   filter of vertices without inverse out degree
 *   filtered vertex counter
 *   job FIFO with room flag for one whole chunk
 */
`timescale 1ns/10ps
`default_nettype none

module vertex_job_queue (
	input  wire                                    clock,
	input  wire                                    rstn,
	input  wire                                    rec_valid,
	input  wire  [vertex_job_pkg::VERTEX_BITS-1:0] rec_id,
	input  wire  [vertex_job_pkg::VERTEX_BITS-1:0] rec_in_degree,
	input  wire  [vertex_job_pkg::VERTEX_BITS-1:0] rec_out_degree,
	input  wire  [vertex_job_pkg::VERTEX_BITS-1:0] rec_edges_idx,
	input  wire  [vertex_job_pkg::VERTEX_BITS-1:0] rec_inverse_in_degree,
	input  wire  [vertex_job_pkg::VERTEX_BITS-1:0] rec_inverse_out_degree,
	input  wire  [vertex_job_pkg::VERTEX_BITS-1:0] rec_inverse_edges_idx,
	input  wire                                    vertex_pop,
	output logic                                   vertex_valid,
	output logic [vertex_job_pkg::VERTEX_BITS-1:0] vertex_id,
	output logic [vertex_job_pkg::VERTEX_BITS-1:0] vertex_in_degree,
	output logic [vertex_job_pkg::VERTEX_BITS-1:0] vertex_out_degree,
	output logic [vertex_job_pkg::VERTEX_BITS-1:0] vertex_edges_idx,
	output logic [vertex_job_pkg::VERTEX_BITS-1:0] vertex_inverse_in_degree,
	output logic [vertex_job_pkg::VERTEX_BITS-1:0] vertex_inverse_out_degree,
	output logic [vertex_job_pkg::VERTEX_BITS-1:0] vertex_inverse_edges_idx,
	output logic [vertex_job_pkg::VERTEX_BITS-1:0] filtered_count,
	output logic                                   chunk_room
);
	import vertex_job_pkg::*;

	logic [VERTEX_RECORD_BITS-1:0] mem [JOB_QUEUE_DEPTH];
	logic [VERTEX_RECORD_BITS-1:0] stage_q;
	logic                          stage_push;
	logic [JOB_QUEUE_PTR_BITS-1:0] wr_ptr;
	logic [JOB_QUEUE_PTR_BITS-1:0] rd_ptr;
	logic [JOB_QUEUE_PTR_BITS:0]   count;
	logic                          keep;
	logic                          pop;

	// Vertices with no inverse out degree never become jobs
	assign keep = rec_valid && (rec_inverse_out_degree != '0);
	assign pop  = vertex_pop && vertex_valid;

	assign vertex_valid = (count != '0);
	assign {vertex_id, vertex_in_degree, vertex_out_degree, vertex_edges_idx,
		vertex_inverse_in_degree, vertex_inverse_out_degree,
		vertex_inverse_edges_idx} = mem[rd_ptr];

	// Record in the stage already claims its entry
	assign chunk_room = (count + {{JOB_QUEUE_PTR_BITS{1'b0}}, stage_push}) <=
		(JOB_QUEUE_PTR_BITS+1)'(JOB_QUEUE_DEPTH - CACHELINE_VERTEX_NUM);

	////////////////////////////////////////////////////////////////////////////
	// Filter stage and counter
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			stage_push     <= 1'b0;
			filtered_count <= '0;
		end else begin
			stage_push <= keep;
			if (rec_valid && !keep)
				filtered_count <= filtered_count + VERTEX_BITS'(1);
		end
	end

	always_ff @(posedge clock) begin
		stage_q <= {rec_id, rec_in_degree, rec_out_degree, rec_edges_idx,
			rec_inverse_in_degree, rec_inverse_out_degree, rec_inverse_edges_idx};
		if (stage_push)
			mem[wr_ptr] <= stage_q;
	end

	////////////////////////////////////////////////////////////////////////////
	// FIFO pointers
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (stage_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (stage_push && !pop)
				count <= count + 1'b1;
			else if (pop && !stage_push)
				count <= count - 1'b1;
		end
	end

	// The sequencer only starts a chunk with room for all of it
	a_no_push_full: assert property (
		@(posedge clock) disable iff (!rstn) stage_push |-> (count != JOB_QUEUE_DEPTH)
	);

endmodule

`default_nettype wire

// File: vertex_job_control.sv
/*
 * Vertex job control top level
 *   read sequencer, line collector and job queue
 */
`timescale 1ns/10ps
`default_nettype none

module vertex_job_control (
	input  wire                                       clock,
	input  wire                                       rstn,
	input  wire                                       job_start,
	input  wire  [vertex_job_pkg::ADDR_BITS-1:0]      vertex_in_degree_base,
	input  wire  [vertex_job_pkg::ADDR_BITS-1:0]      vertex_out_degree_base,
	input  wire  [vertex_job_pkg::ADDR_BITS-1:0]      vertex_edges_idx_base,
	input  wire  [vertex_job_pkg::ADDR_BITS-1:0]      inverse_in_degree_base,
	input  wire  [vertex_job_pkg::ADDR_BITS-1:0]      inverse_out_degree_base,
	input  wire  [vertex_job_pkg::ADDR_BITS-1:0]      inverse_edges_idx_base,
	input  wire  [vertex_job_pkg::VERTEX_BITS-1:0]    num_vertices,
	input  wire                                       resp_valid,
	input  wire vertex_job_pkg::vertex_array_e        resp_array,
	input  wire  [vertex_job_pkg::CACHELINE_BITS-1:0] resp_data,
	input  wire                                       vertex_pop,
	output logic                                      rd_valid,
	output logic [vertex_job_pkg::ADDR_BITS-1:0]      rd_addr,
	output vertex_job_pkg::vertex_array_e             rd_array,
	output logic [vertex_job_pkg::VERTEX_BITS-1:0]    rd_count,
	output logic                                      busy,
	output logic                                      vertex_valid,
	output logic [vertex_job_pkg::VERTEX_BITS-1:0]    vertex_id,
	output logic [vertex_job_pkg::VERTEX_BITS-1:0]    vertex_in_degree,
	output logic [vertex_job_pkg::VERTEX_BITS-1:0]    vertex_out_degree,
	output logic [vertex_job_pkg::VERTEX_BITS-1:0]    vertex_edges_idx,
	output logic [vertex_job_pkg::VERTEX_BITS-1:0]    vertex_inverse_in_degree,
	output logic [vertex_job_pkg::VERTEX_BITS-1:0]    vertex_inverse_out_degree,
	output logic [vertex_job_pkg::VERTEX_BITS-1:0]    vertex_inverse_edges_idx,
	output logic [vertex_job_pkg::VERTEX_BITS-1:0]    filtered_count
);
	import vertex_job_pkg::*;

	// Collector to queue
	logic                   rec_valid;
	logic [VERTEX_BITS-1:0] rec_id;
	logic [VERTEX_BITS-1:0] rec_in_degree;
	logic [VERTEX_BITS-1:0] rec_out_degree;
	logic [VERTEX_BITS-1:0] rec_edges_idx;
	logic [VERTEX_BITS-1:0] rec_inverse_in_degree;
	logic [VERTEX_BITS-1:0] rec_inverse_out_degree;
	logic [VERTEX_BITS-1:0] rec_inverse_edges_idx;
	// Flow control back to the sequencer
	logic                   drain_busy;
	logic                   chunk_room;

	vertex_read_sequencer u_vertex_read_sequencer (
		.clock                  (clock),
		.rstn                   (rstn),
		.job_start              (job_start),
		.vertex_in_degree_base  (vertex_in_degree_base),
		.vertex_out_degree_base (vertex_out_degree_base),
		.vertex_edges_idx_base  (vertex_edges_idx_base),
		.inverse_in_degree_base (inverse_in_degree_base),
		.inverse_out_degree_base(inverse_out_degree_base),
		.inverse_edges_idx_base (inverse_edges_idx_base),
		.num_vertices           (num_vertices),
		.resp_valid             (resp_valid),
		.drain_busy             (drain_busy),
		.chunk_room             (chunk_room),
		.rd_valid               (rd_valid),
		.rd_addr                (rd_addr),
		.rd_array               (rd_array),
		.rd_count               (rd_count),
		.busy                   (busy)
	);

	vertex_line_collector u_vertex_line_collector (
		.clock                 (clock),
		.rstn                  (rstn),
		.job_start             (job_start),
		.rd_valid              (rd_valid),
		.rd_array              (rd_array),
		.rd_count              (rd_count),
		.resp_valid            (resp_valid),
		.resp_array            (resp_array),
		.resp_data             (resp_data),
		.rec_valid             (rec_valid),
		.rec_id                (rec_id),
		.rec_in_degree         (rec_in_degree),
		.rec_out_degree        (rec_out_degree),
		.rec_edges_idx         (rec_edges_idx),
		.rec_inverse_in_degree (rec_inverse_in_degree),
		.rec_inverse_out_degree(rec_inverse_out_degree),
		.rec_inverse_edges_idx (rec_inverse_edges_idx),
		.drain_busy            (drain_busy)
	);

	vertex_job_queue u_vertex_job_queue (
		.clock                    (clock),
		.rstn                     (rstn),
		.rec_valid                (rec_valid),
		.rec_id                   (rec_id),
		.rec_in_degree            (rec_in_degree),
		.rec_out_degree           (rec_out_degree),
		.rec_edges_idx            (rec_edges_idx),
		.rec_inverse_in_degree    (rec_inverse_in_degree),
		.rec_inverse_out_degree   (rec_inverse_out_degree),
		.rec_inverse_edges_idx    (rec_inverse_edges_idx),
		.vertex_pop               (vertex_pop),
		.vertex_valid             (vertex_valid),
		.vertex_id                (vertex_id),
		.vertex_in_degree         (vertex_in_degree),
		.vertex_out_degree        (vertex_out_degree),
		.vertex_edges_idx         (vertex_edges_idx),
		.vertex_inverse_in_degree (vertex_inverse_in_degree),
		.vertex_inverse_out_degree(vertex_inverse_out_degree),
		.vertex_inverse_edges_idx (vertex_inverse_edges_idx),
		.filtered_count           (filtered_count),
		.chunk_room               (chunk_room)
	);

endmodule

`default_nettype wire

// File: tb_vertex_job_control.sv
/*
 * Testbench of the vertex job control unit
 *   clock, reset and job sequence from the vectors file
 *   memory responder with random delay and answer order
 *   consumer with pop stalls, reference records and checks
 */
`timescale 1ns/10ps
`default_nettype none

module tb_vertex_job_control;
	import vertex_job_pkg::*;

	// Vectors file holds the memory words first and the job table behind them
	localparam int MEM_WORDS     = 1024;
	localparam int JOB_TABLE     = 1024;
	localparam int JOB_WORDS     = 10;
	localparam int VEC_WORDS     = 1088;
	localparam int BUSY_TIMEOUT  = 4000;
	localparam int DRAIN_TIMEOUT = 2000;

	logic                      clock;
	logic                      rstn;
	logic                      job_start;
	logic [ADDR_BITS-1:0]      base_in [VERTEX_ARRAY_NUM];
	logic [VERTEX_BITS-1:0]    num_vertices;
	logic                      resp_valid = 1'b0;
	vertex_array_e             resp_array = IN_DEGREE;
	logic [CACHELINE_BITS-1:0] resp_data = '0;
	logic                      vertex_pop = 1'b0;
	logic                      rd_valid;
	logic [ADDR_BITS-1:0]      rd_addr;
	vertex_array_e             rd_array;
	logic [VERTEX_BITS-1:0]    rd_count;
	logic                      busy;
	logic                      vertex_valid;
	logic [VERTEX_BITS-1:0]    vertex_id;
	logic [VERTEX_BITS-1:0]    vertex_in_degree;
	logic [VERTEX_BITS-1:0]    vertex_out_degree;
	logic [VERTEX_BITS-1:0]    vertex_edges_idx;
	logic [VERTEX_BITS-1:0]    vertex_inverse_in_degree;
	logic [VERTEX_BITS-1:0]    vertex_inverse_out_degree;
	logic [VERTEX_BITS-1:0]    vertex_inverse_edges_idx;
	logic [VERTEX_BITS-1:0]    filtered_count;

	logic [31:0]                   vec [VEC_WORDS];
	logic [VERTEX_RECORD_BITS-1:0] exp_records [$];
	logic [ADDR_BITS-1:0]          pend_addr [$];
	vertex_array_e                 pend_array [$];
	int                            pend_due [$];
	logic [15:0]                   lfsr_state = 16'd43986;
	logic [31:0]                   cur_count = '0;
	logic [31:0]                   cur_stall = '0;
	logic [31:0]                   cur_pop_mask = '0;
	logic [31:0]                   pop_mask_q = '0;
	logic                          prev_rd_valid = 1'b0;
	int                            cur_row = 0;
	int                            cmd_idx = 0;
	int                            resp_count = 0;
	int                            stall_left = 0;
	int                            pop_phase = 0;
	int                            cycle = 0;
	int                            errors = 0;

	vertex_job_control u_vertex_job_control (
		.clock                    (clock),
		.rstn                     (rstn),
		.job_start                (job_start),
		.vertex_in_degree_base    (base_in[IN_DEGREE]),
		.vertex_out_degree_base   (base_in[OUT_DEGREE]),
		.vertex_edges_idx_base    (base_in[EDGES_IDX]),
		.inverse_in_degree_base   (base_in[INV_IN_DEGREE]),
		.inverse_out_degree_base  (base_in[INV_OUT_DEGREE]),
		.inverse_edges_idx_base   (base_in[INV_EDGES_IDX]),
		.num_vertices             (num_vertices),
		.resp_valid               (resp_valid),
		.resp_array               (resp_array),
		.resp_data                (resp_data),
		.vertex_pop               (vertex_pop),
		.rd_valid                 (rd_valid),
		.rd_addr                  (rd_addr),
		.rd_array                 (rd_array),
		.rd_count                 (rd_count),
		.busy                     (busy),
		.vertex_valid             (vertex_valid),
		.vertex_id                (vertex_id),
		.vertex_in_degree         (vertex_in_degree),
		.vertex_out_degree        (vertex_out_degree),
		.vertex_edges_idx         (vertex_edges_idx),
		.vertex_inverse_in_degree (vertex_inverse_in_degree),
		.vertex_inverse_out_degree(vertex_inverse_out_degree),
		.vertex_inverse_edges_idx (vertex_inverse_edges_idx),
		.filtered_count           (filtered_count)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	////////////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////////////
	function automatic logic [31:0] byte_reverse(input logic [31:0] w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	// Every word of the memory differs, so a wrong address shows up
	function automatic logic [31:0] address_fill(input int a);
		logic [15:0] low;
		low = 16'(a);
		return {low ^ 16'hbeef, low + 16'h1234};
	endfunction

	function automatic int take_random_bits(input int n);
		int bits;
		int k;
		bits = 0;
		for (k = 0; k < n; k++) begin
			bits = (bits << 1) | int'(lfsr_state[0]);
			if (lfsr_state[0])
				lfsr_state = (lfsr_state >> 1) ^ 16'hb400;
			else
				lfsr_state = lfsr_state >> 1;
		end
		return bits;
	endfunction

	function automatic logic [31:0] field_word(input int row, input int a, input int i);
		int word;
		word = int'(vec[row + a] >> 2) + i;
		return byte_reverse(vec[word]);
	endfunction

	task automatic report_failure(input string what);
		errors = errors + 1;
		$display("%s", what);
		$display("TEST FAILED");
		$fatal(1, "Simulation stopped at the first failure");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected)
			report_failure($sformatf("ERROR %s got 0x%h expected 0x%h", name, got, expected));
	endtask

	// Expected records of one job in pop order
	task automatic build_model(input int row);
		logic [VERTEX_BITS-1:0] fields [VERTEX_ARRAY_NUM];
		int i;
		int a;
		exp_records.delete();
		for (i = 0; i < int'(vec[row + 6]); i++) begin
			for (a = 0; a < VERTEX_ARRAY_NUM; a++)
				fields[a] = field_word(row, a, i);
			if (fields[INV_OUT_DEGREE] != '0)
				exp_records.push_back({VERTEX_BITS'(i), fields[IN_DEGREE], fields[OUT_DEGREE],
					fields[EDGES_IDX], fields[INV_IN_DEGREE], fields[INV_OUT_DEGREE],
					fields[INV_EDGES_IDX]});
		end
	endtask

	task automatic check_popped_vertex();
		logic [VERTEX_RECORD_BITS-1:0] rec;
		if (exp_records.size() == 0) begin
			report_failure("A vertex was popped while no more vertices were expected");
		end else begin
			rec = exp_records.pop_front();
			check_value("vertex_id", vertex_id, rec[6*VERTEX_BITS +: VERTEX_BITS]);
			check_value("vertex_in_degree", vertex_in_degree, rec[5*VERTEX_BITS +: VERTEX_BITS]);
			check_value("vertex_out_degree", vertex_out_degree, rec[4*VERTEX_BITS +: VERTEX_BITS]);
			check_value("vertex_edges_idx", vertex_edges_idx, rec[3*VERTEX_BITS +: VERTEX_BITS]);
			check_value("vertex_inverse_in_degree", vertex_inverse_in_degree,
				rec[2*VERTEX_BITS +: VERTEX_BITS]);
			check_value("vertex_inverse_out_degree", vertex_inverse_out_degree,
				rec[VERTEX_BITS +: VERTEX_BITS]);
			check_value("vertex_inverse_edges_idx", vertex_inverse_edges_idx,
				rec[0 +: VERTEX_BITS]);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Memory responder and read command checks
	////////////////////////////////////////////////////////////////////////////
	always @(posedge clock) begin
		int ready [$];
		int chunk;
		int arr;
		int left;
		int pick;
		int word;
		int k;
		if (rstn) begin
			cycle = cycle + 1;
			resp_valid <= 1'b0;
			if (job_start) begin
				cmd_idx = 0;
				resp_count = 0;
			end
			if (rd_valid) begin
				chunk = cmd_idx / VERTEX_ARRAY_NUM;
				arr = cmd_idx % VERTEX_ARRAY_NUM;
				left = int'(cur_count) - chunk * CACHELINE_VERTEX_NUM;
				if (left <= 0) begin
					report_failure("A read command came after the last chunk of the job");
				end else begin
					// Six commands of a chunk come back to back
					if (arr != 0)
						check_value("rd_valid before this command", 32'(prev_rd_valid), 32'd1);
					check_value("rd_array", 32'(rd_array), 32'(arr));
					check_value("rd_addr", rd_addr,
						vec[cur_row + arr] + 32'(chunk * CACHELINE_BYTES));
					check_value("rd_count", rd_count,
						32'((left > CACHELINE_VERTEX_NUM) ? CACHELINE_VERTEX_NUM : left));
				end
				pend_addr.push_back(rd_addr);
				pend_array.push_back(rd_array);
				pend_due.push_back(cycle + 1 + take_random_bits(3));
				cmd_idx = cmd_idx + 1;
			end
			ready.delete();
			for (k = 0; k < pend_due.size(); k++)
				if (pend_due[k] <= cycle)
					ready.push_back(k);
			if (ready.size() != 0) begin
				pick = ready[take_random_bits(3) % ready.size()];
				word = int'(pend_addr[pick] >> 2);
				resp_valid <= 1'b1;
				resp_array <= pend_array[pick];
				resp_data <= {vec[word], vec[word + 1], vec[word + 2], vec[word + 3]};
				pend_addr.delete(pick);
				pend_array.delete(pick);
				pend_due.delete(pick);
				resp_count = resp_count + 1;
			end
			prev_rd_valid = rd_valid;
		end
	end

	// Consumer with an initial stall and a repeating pop mask
	always @(posedge clock) begin
		if (rstn) begin
			if (vertex_pop && vertex_valid)
				check_popped_vertex();
			if (job_start) begin
				stall_left = int'(cur_stall);
				pop_mask_q = cur_pop_mask;
			end
			if (stall_left != 0) begin
				stall_left = stall_left - 1;
				vertex_pop <= 1'b0;
			end else begin
				vertex_pop <= pop_mask_q[pop_phase];
			end
			pop_phase = (pop_phase + 1) % 32;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Job sequence
	////////////////////////////////////////////////////////////////////////////
	task automatic run_job(input int j);
		logic [VERTEX_BITS-1:0] start_filtered;
		int row;
		int chunks;
		int waited;
		int a;
		row = JOB_TABLE + 1 + j * JOB_WORDS;
		build_model(row);
		chunks = (int'(vec[row + 6]) + CACHELINE_VERTEX_NUM - 1) / CACHELINE_VERTEX_NUM;
		start_filtered = filtered_count;
		cur_row = row;
		cur_count = vec[row + 6];
		cur_stall = vec[row + 8];
		cur_pop_mask = vec[row + 9];
		job_start <= 1'b1;
		for (a = 0; a < VERTEX_ARRAY_NUM; a++)
			base_in[a] <= vec[row + a];
		num_vertices <= vec[row + 6];
		@(posedge clock);
		job_start <= 1'b0;
		@(posedge clock);
		check_value("busy", 32'(busy), 32'd1);
		waited = 0;
		while (busy) begin
			if (waited >= BUSY_TIMEOUT) begin
				report_failure($sformatf("Timeout waiting for busy to fall in job %0d", j));
			end else begin
				@(posedge clock);
				waited = waited + 1;
			end
		end
		// All chunks issued, returned and drained once busy is low
		check_value("read commands", 32'(cmd_idx), 32'(6 * chunks));
		check_value("read responses", 32'(resp_count), 32'(6 * chunks));
		check_value("filtered_count delta", filtered_count - start_filtered, vec[row + 7]);
		waited = 0;
		while (exp_records.size() != 0) begin
			if (waited >= DRAIN_TIMEOUT) begin
				report_failure($sformatf(
					"Timeout, %0d vertices of job %0d never reached the consumer",
					exp_records.size(), j));
			end else begin
				@(posedge clock);
				waited = waited + 1;
			end
		end
		@(posedge clock);
		check_value("vertex_valid", 32'(vertex_valid), 32'd0);
	endtask

	initial begin
		int jobs;
		int a;
		int j;
		rstn = 1'b0;
		job_start = 1'b0;
		num_vertices = '0;
		for (a = 0; a < VERTEX_ARRAY_NUM; a++)
			base_in[a] = '0;
		for (a = 0; a < MEM_WORDS; a++)
			vec[a] = address_fill(a);
		$readmemh("vertex_job_vectors.txt", vec);
		jobs = int'(vec[JOB_TABLE]);
		repeat (8) @(posedge clock);
		rstn <= 1'b1;
		@(posedge clock);
		check_value("rd_valid", 32'(rd_valid), 32'd0);
		check_value("busy", 32'(busy), 32'd0);
		check_value("vertex_valid", 32'(vertex_valid), 32'd0);
		check_value("filtered_count", filtered_count, 32'd0);
		for (j = 0; j < jobs; j++)
			run_job(j);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: vertex_job_vectors.txt
// Memory words by word address (byte address / 4), unlisted words keep the address fill
// Job table at 0x400: job count, then per job six bases, vertex count, filtered delta,
// initial pop stall in cycles and pop mask
@000 11223344 55667788 99aabbcc ddeeff00
// Zero inverse out degree words of jobs 1, 2 and 3
@112 00000000
@117 00000000
@11a 00000000
@180 00000000
@193 00000000
@1a4 00000000
@341 00000000
@400 00000004
// Job 0: two full chunks, nothing filtered
@401 00000000 00000100 00000200 00000300 00000400 00000500 00000008 00000000 00000000 ffffffff
// Job 1: short last chunk, three filtered, uneven pops
@40b 00000040 00000140 00000240 00000340 00000440 00000540 0000000b 00000003 00000000 5a5a5a5a
// Job 2: long consumer stall fills the queue
@415 00000800 00000900 00000a00 00000b00 00000600 00000c00 00000025 00000003 0000012c aaaaaaaa
// Job 3: one short chunk, one filtered
@41f 00000e00 00000e40 00000e80 00000ec0 00000d00 00000f00 00000002 00000001 00000000 ffffffff

// File: project.f
vertex_job_pkg.sv
vertex_read_sequencer.sv
vertex_line_collector.sv
vertex_job_queue.sv
vertex_job_control.sv
tb_vertex_job_control.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Verilator build and run of the vertex job control testbench

cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_vertex_job_control \
	-f project.f > build.log 2>&1 \
	&& ./obj_dir/Vtb_vertex_job_control > sim.log 2>&1 \
	|| echo "Build or simulation ended with an error, see build.log and sim.log"

grep -qsx "TEST PASSED" sim.log \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
